/* verilog/txCtrlPkg.sv */
package txCtrlPkg;

	// transducer channels and the width of their timing fields
	localparam int numChannels = 8;
	localparam int timingWidth = 16;

	// control commands, codes as seen on the control bus
	typedef enum logic [7:0]
	{
		hardReset   = 8'h00,
		softReset   = 8'h01,
		loadProgram = 8'h02,
		setTrig     = 8'h04,
		setTrigRest = 8'h05,
		testTrig    = 8'h06,
		setLed      = 8'h08,
		runProgram  = 8'h80
	} txCmd_e;

	typedef struct packed
	{
		logic [7:0] led;
		logic [7:0] trig;
		logic [7:0] trigRest;
	} manualRegs_t;

	// both fields in clock cycles
	typedef struct packed
	{
		logic [timingWidth-1:0] delay;
		logic [timingWidth-1:0] width;
	} chanTiming_t;

	typedef struct packed
	{
		logic running;
		logic done;
		logic fault;
	} txStatus_t;

	typedef struct packed
	{
		logic runMode;
		logic manualMode;
		logic loadMode;
		logic clearFault;
	} modeFlags_t;

endpackage

/* verilog/txProgPkg.sv */
package txProgPkg;

	localparam int progDepth = 64;
	localparam int progAddrWidth = 6;
	localparam int argWidth = 16;
	localparam int holdWidth = 16;

	typedef enum logic [3:0]
	{
		setTrigOp     = 4'd0,
		setLedsOp     = 4'd1,
		triggerRecvOp = 4'd2,
		firePulseOp   = 4'd5,
		programEndOp  = 4'd15
	} txOpcode_e;

	// arg carries the trigger value in the low byte, LEDs in the high byte
	typedef struct packed
	{
		txOpcode_e opcode;
		logic [argWidth-1:0] arg;
		logic [holdWidth-1:0] hold;
	} instrWord_t;

	typedef struct packed
	{
		logic valid;
		logic [progAddrWidth-1:0] addr;
		instrWord_t word;
	} progWrite_t;

endpackage

/* verilog/txModeControl.sv */
module txModeControl
(
	input  logic txCLK,
	input  logic rstN,
	input  txCtrlPkg::txCmd_e txCmd,
	input  txCtrlPkg::manualRegs_t manualRegs,
	output txCtrlPkg::modeFlags_t modeFlags,
	output logic [7:0] trigRest,
	output logic [7:0] manualTrig,
	output logic [7:0] manualLed
);
	import txCtrlPkg::*;

	always_ff @(posedge txCLK)
	begin
		if (!rstN)
		begin
			modeFlags <= '0;
			trigRest <= '0;
			manualTrig <= '0;
			manualLed <= '0;
		end
		else
		begin
			modeFlags.runMode <= (txCmd == runProgram);
			modeFlags.manualMode <= (txCmd == setTrig) || (txCmd == testTrig) || (txCmd == setLed);
			modeFlags.loadMode <= (txCmd == loadProgram);
			modeFlags.clearFault <= (txCmd == hardReset) || (txCmd == softReset)
				|| (txCmd == loadProgram);

			case (txCmd)
				setTrig:
					manualTrig <= manualRegs.trig;
				testTrig:
					manualTrig <= manualRegs.trig ^ trigRest;
				setLed:
					manualLed <= manualRegs.led;
				setTrigRest:
				begin
					// rest level is frozen while a program is running
					if (!modeFlags.runMode)
					begin
						trigRest <= manualRegs.trigRest;
					end
				end
				hardReset:
				begin
					trigRest <= '0;
					manualTrig <= '0;
					manualLed <= '0;
				end
				default:
				begin
					// back to safe values, so a later manual command starts clean
					manualTrig <= trigRest;
					manualLed <= '0;
				end
			endcase
		end
	end

endmodule

/* verilog/programMemory.sv */
module programMemory
(
	input  logic txCLK,
	input  logic loadMode,
	input  txProgPkg::progWrite_t progWrite,
	input  logic [txProgPkg::progAddrWidth-1:0] readAddr,
	output txProgPkg::instrWord_t readWord
);
	import txProgPkg::*;

	instrWord_t mem [progDepth];

	always_ff @(posedge txCLK)
	begin
		// writes only land while the load command is active
		if (loadMode && progWrite.valid)
		begin
			mem[progWrite.addr] <= progWrite.word;
		end
		readWord <= mem[readAddr];
	end

endmodule

/* verilog/instructionSequencer.sv */
module instructionSequencer
(
	input  logic txCLK,
	input  logic rstN,
	input  txCtrlPkg::modeFlags_t modeFlags,
	input  logic [7:0] trigRest,
	input  txProgPkg::instrWord_t readWord,
	input  logic [txCtrlPkg::numChannels-1:0] chanActive,
	input  logic [txCtrlPkg::numChannels-1:0] chanMask,
	input  logic adcAck,
	output logic [txProgPkg::progAddrWidth-1:0] readAddr,
	output logic [txCtrlPkg::numChannels-1:0] fire,
	output logic [7:0] progTrig,
	output logic [7:0] progLed,
	output logic [1:0] progValid,
	output logic adcTrigger,
	output txCtrlPkg::txStatus_t status,
	output logic [txCtrlPkg::numChannels-1:0] transducerErr
);
	import txCtrlPkg::*;
	import txProgPkg::*;

	typedef enum logic [2:0]
	{
		seqIdle,
		seqFetch,
		seqDecode,
		seqExec,
		seqHold,
		seqStop
	} seqState_e;

	seqState_e state;
	instrWord_t instr;
	logic [holdWidth-1:0] holdCount;

	// progValid bit 1 is the trigger value, bit 0 the LEDs
	always_ff @(posedge txCLK)
	begin
		if (!rstN)
		begin
			state <= seqIdle;
			readAddr <= '0;
			holdCount <= '0;
			fire <= '0;
			progValid <= '0;
			adcTrigger <= 1'b0;
			status <= '0;
			transducerErr <= '0;
		end
		else
		begin
			fire <= '0;
			if (adcTrigger && adcAck)
			begin
				adcTrigger <= 1'b0;
			end

			if (modeFlags.clearFault)
			begin
				state <= seqIdle;
				readAddr <= '0;
				progValid <= '0;
				adcTrigger <= 1'b0;
				status <= '0;
				transducerErr <= '0;
			end
			else if (!modeFlags.runMode)
			begin
				state <= seqIdle;
				readAddr <= '0;
				progValid <= '0;
				status.running <= 1'b0;
			end
			else
			begin
				case (state)
					seqIdle:
					begin
						// a latched fault keeps the program from starting
						if (!status.fault)
						begin
							status.running <= 1'b1;
							status.done <= 1'b0;
							state <= seqFetch;
						end
					end
					seqFetch:
						state <= seqDecode;
					seqDecode:
					begin
						instr <= readWord;
						readAddr <= readAddr + 1'b1;
						state <= seqExec;
					end
					seqExec:
					begin
						if (instr.hold == '0)
						begin
							state <= seqFetch;
						end
						else
						begin
							holdCount <= instr.hold;
							state <= seqHold;
						end

						case (instr.opcode)
							setTrigOp:
							begin
								progTrig <= instr.arg[7:0] ^ trigRest;
								progValid[1] <= 1'b1;
							end
							setLedsOp:
							begin
								progLed <= instr.arg[15:8];
								progValid[0] <= 1'b1;
							end
							triggerRecvOp:
								adcTrigger <= 1'b1;
							firePulseOp:
							begin
								if (|chanActive)
								begin
									status.fault <= 1'b1;
									status.running <= 1'b0;
									transducerErr <= chanActive;
									state <= seqStop;
								end
								else
								begin
									fire <= chanMask;
								end
							end
							programEndOp:
							begin
								status.done <= 1'b1;
								status.running <= 1'b0;
								state <= seqStop;
							end
							default:
								;
						endcase
					end
					seqHold:
					begin
						holdCount <= holdCount - 1'b1;
						if (holdCount == 1)
						begin
							state <= seqFetch;
						end
					end
					default:
						// stopped until runMode drops or the fault is cleared
						state <= seqStop;
				endcase
			end
		end
	end

endmodule

/* verilog/pulseChannel.sv */
module pulseChannel
(
	input  logic txCLK,
	input  logic rstN,
	input  logic fire,
	input  logic enable,
	input  txCtrlPkg::chanTiming_t timing,
	input  logic abort,
	output logic pulseOut,
	output logic active
);
	import txCtrlPkg::*;

	logic [timingWidth:0] count;
	logic [timingWidth:0] startCount;
	logic [timingWidth:0] endCount;

	always_ff @(posedge txCLK)
	begin
		if (!rstN || abort)
		begin
			active <= 1'b0;
			count <= '0;
		end
		else if (fire && enable && (timing.width != '0))
		begin
			active <= 1'b1;
			count <= '0;
			startCount <= {1'b0, timing.delay};
			endCount <= {1'b0, timing.delay} + {1'b0, timing.width};
		end
		else if (active)
		begin
			count <= count + 1'b1;
			// drop active right after the last high cycle
			if (count + 1'b1 == endCount)
			begin
				active <= 1'b0;
			end
		end
	end

	assign pulseOut = active && (count >= startCount);

endmodule

/* verilog/txOutputStage.sv */
module txOutputStage
(
	input  logic txCLK,
	input  logic rstN,
	input  txCtrlPkg::modeFlags_t modeFlags,
	input  logic [7:0] trigRest,
	input  logic [7:0] manualTrig,
	input  logic [7:0] manualLed,
	input  logic [7:0] progTrig,
	input  logic [7:0] progLed,
	input  logic [1:0] progValid,
	input  logic [txCtrlPkg::numChannels-1:0] pulseOut,
	input  logic fault,
	output logic [7:0] trigOut,
	output logic [7:0] ledOut,
	output logic [txCtrlPkg::numChannels-1:0] transducerOut
);
	import txCtrlPkg::*;

	always_ff @(posedge txCLK)
	begin
		if (!rstN)
		begin
			trigOut <= '0;
			ledOut <= '0;
			transducerOut <= '0;
		end
		else if (modeFlags.runMode)
		begin
			// until the program writes a value the safe one stays on the pins
			trigOut <= progValid[1] ? progTrig : trigRest;
			ledOut <= progValid[0] ? progLed : 8'h00;
			transducerOut <= fault ? '0 : pulseOut;
		end
		else if (modeFlags.manualMode)
		begin
			trigOut <= manualTrig;
			ledOut <= manualLed;
			transducerOut <= '0;
		end
		else
		begin
			trigOut <= trigRest;
			ledOut <= 8'h00;
			transducerOut <= {numChannels{1'b0}};
		end
	end

endmodule

/* verilog/sonicTxTop.sv */
module sonicTxTop
(
	input  logic txCLK,
	input  logic rstN,
	input  txCtrlPkg::txCmd_e txCmd,
	input  txCtrlPkg::manualRegs_t manualRegs,
	input  txProgPkg::progWrite_t progWrite,
	input  txCtrlPkg::chanTiming_t [txCtrlPkg::numChannels-1:0] chanTiming,
	input  logic [txCtrlPkg::numChannels-1:0] chanMask,
	input  logic adcAck,
	output logic [txCtrlPkg::numChannels-1:0] transducerOut,
	output logic [txCtrlPkg::numChannels-1:0] transducerErr,
	output logic [7:0] trigOut,
	output logic [7:0] ledOut,
	output logic adcTrigger,
	output txCtrlPkg::txStatus_t status
);
	import txCtrlPkg::*;
	import txProgPkg::*;

	modeFlags_t modeFlags;
	logic [7:0] trigRest;
	logic [7:0] manualTrig;
	logic [7:0] manualLed;
	logic [progAddrWidth-1:0] readAddr;
	instrWord_t readWord;
	logic [numChannels-1:0] fire;
	logic [numChannels-1:0] chanActive;
	logic [numChannels-1:0] pulseOut;
	logic [7:0] progTrig;
	logic [7:0] progLed;
	logic [1:0] progValid;

	txModeControl txModeControl_inst
	(
		.txCLK(txCLK),
		.rstN(rstN),
		.txCmd(txCmd),
		.manualRegs(manualRegs),
		.modeFlags(modeFlags),
		.trigRest(trigRest),
		.manualTrig(manualTrig),
		.manualLed(manualLed)
	);

	programMemory programMemory_inst
	(
		.txCLK(txCLK),
		.loadMode(modeFlags.loadMode),
		.progWrite(progWrite),
		.readAddr(readAddr),
		.readWord(readWord)
	);

	instructionSequencer instructionSequencer_inst
	(
		.txCLK(txCLK),
		.rstN(rstN),
		.modeFlags(modeFlags),
		.trigRest(trigRest),
		.readWord(readWord),
		.chanActive(chanActive),
		.chanMask(chanMask),
		.adcAck(adcAck),
		.readAddr(readAddr),
		.fire(fire),
		.progTrig(progTrig),
		.progLed(progLed),
		.progValid(progValid),
		.adcTrigger(adcTrigger),
		.status(status),
		.transducerErr(transducerErr)
	);

	// channels only arm while a program runs, a fault aborts them all
	for (genvar ch = 0; ch < numChannels; ch++)
	begin : genChannel
		pulseChannel pulseChannel_inst
		(
			.txCLK(txCLK),
			.rstN(rstN),
			.fire(fire[ch]),
			.enable(modeFlags.runMode),
			.timing(chanTiming[ch]),
			.abort(status.fault),
			.pulseOut(pulseOut[ch]),
			.active(chanActive[ch])
		);
	end

	txOutputStage txOutputStage_inst
	(
		.txCLK(txCLK),
		.rstN(rstN),
		.modeFlags(modeFlags),
		.trigRest(trigRest),
		.manualTrig(manualTrig),
		.manualLed(manualLed),
		.progTrig(progTrig),
		.progLed(progLed),
		.progValid(progValid),
		.pulseOut(pulseOut),
		.fault(status.fault),
		.trigOut(trigOut),
		.ledOut(ledOut),
		.transducerOut(transducerOut)
	);

endmodule

/* test/sonicTx_properties.sv */
module sonicTxProperties
(
	input logic txCLK,
	input logic rstN,
	input logic adcAck,
	input logic adcTrigger,
	input logic [7:0] trigOut,
	input logic [7:0] ledOut,
	input logic [txCtrlPkg::numChannels-1:0] transducerOut,
	input txCtrlPkg::txStatus_t status
);
	timeunit 1ns;
	timeprecision 100ps;
	import txCtrlPkg::*;

	int failCount = 0;

	// the output register lags the fault latch by one cycle
	faultSilence: assert property (@(posedge txCLK) disable iff (!rstN)
		status.fault && $past(status.fault) |-> transducerOut == '0)
	else
	begin
		$error("transducerOut active while status.fault is set");
		failCount++;
	end

	runDoneExclusive: assert property (@(posedge txCLK) disable iff (!rstN)
		!(status.running && status.done))
	else
	begin
		$error("status.running and status.done both high");
		failCount++;
	end

	adcAckDrop: assert property (@(posedge txCLK) disable iff (!rstN)
		adcTrigger && adcAck |=> !adcTrigger)
	else
	begin
		$error("adcTrigger still high after adcAck");
		failCount++;
	end

	// a command needs two cycles to reach the pins
	resetQuiet: assert property (@(posedge txCLK)
		!rstN |=> (trigOut == '0 && ledOut == '0 && transducerOut == '0
			&& !adcTrigger && status == '0) [*2])
	else
	begin
		$error("outputs not low after reset");
		failCount++;
	end

endmodule

bind sonicTxTop sonicTxProperties propsInst
(
	.txCLK(txCLK),
	.rstN(rstN),
	.adcAck(adcAck),
	.adcTrigger(adcTrigger),
	.trigOut(trigOut),
	.ledOut(ledOut),
	.transducerOut(transducerOut),
	.status(status)
);

/* test/sonicTxTb.sv */
module sonicTxTb;
	timeunit 1ns;
	timeprecision 100ps;
	import txCtrlPkg::*;
	import txProgPkg::*;

	logic txCLK;
	logic rstN;
	txCmd_e txCmd;
	manualRegs_t manualRegs;
	progWrite_t progWrite;
	chanTiming_t [numChannels-1:0] chanTiming;
	logic [numChannels-1:0] chanMask;
	logic adcAck;
	logic [numChannels-1:0] transducerOut;
	logic [numChannels-1:0] transducerErr;
	logic [7:0] trigOut;
	logic [7:0] ledOut;
	logic adcTrigger;
	txStatus_t status;

	logic [31:0] lfsr = 32'd80599;
	instrWord_t prog [$];
	logic [15:0] expected [$];
	logic monitorOn = 1'b0;
	logic [15:0] lastSeen;
	int pulseCount [numChannels];
	chanTiming_t [numChannels-1:0] timings;
	logic [7:0] restLevel;

	sonicTxTop sonicTxTop_inst
	(
		.txCLK(txCLK),
		.rstN(rstN),
		.txCmd(txCmd),
		.manualRegs(manualRegs),
		.progWrite(progWrite),
		.chanTiming(chanTiming),
		.chanMask(chanMask),
		.adcAck(adcAck),
		.transducerOut(transducerOut),
		.transducerErr(transducerErr),
		.trigOut(trigOut),
		.ledOut(ledOut),
		.adcTrigger(adcTrigger),
		.status(status)
	);

	initial
	begin
		txCLK = 1'b0;
		forever
			#2 txCLK = ~txCLK;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsrNext(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic drawBits(input int n, output logic [15:0] value);
		value = '0;
		repeat (n)
		begin
			lfsr = lfsrNext(lfsr);
			value = {value[14:0], lfsr[0]};
		end
	endtask

	// no command code decodes to 0x40
	function automatic txCmd_e idleCommand();
		return txCmd_e'(8'h40);
	endfunction

	function automatic instrWord_t makeInstr(input txOpcode_e op, input logic [15:0] arg,
		input logic [15:0] hold);
		instrWord_t word;
		word.opcode = op;
		word.arg = arg;
		word.hold = hold;
		return word;
	endfunction

	// expected {trigOut, ledOut} once an instruction has executed
	function automatic logic [15:0] refOutputs(input instrWord_t word, input logic [7:0] rest,
		input logic [15:0] prev);
		logic [15:0] next;
		next = prev;
		case (word.opcode)
			setTrigOp:
				next[15:8] = word.arg[7:0] ^ rest;
			setLedsOp:
				next[7:0] = word.arg[15:8];
			default:
				;
		endcase
		return next;
	endfunction

	task automatic reportFailure(input string message);
		$display("%s", message);
		$display(">>> FAIL");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] want);
		if (got !== want)
			reportFailure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, want));
	endtask

	task automatic checkStatus(input string name, input txStatus_t got, input txStatus_t want);
		if (got !== want)
			reportFailure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, want));
	endtask

	// 0 is status.done, 1 status.fault, anything else adcTrigger
	function automatic logic flagValue(input int which);
		case (which)
			0: return status.done;
			1: return status.fault;
			default: return adcTrigger;
		endcase
	endfunction

	task automatic waitFlag(input int which, input logic level, input string what);
		int cycles;
		cycles = 0;
		do
		begin
			@(negedge txCLK);
			cycles++;
			if (cycles > 200)
				reportFailure($sformatf("timed out after 200 cycles waiting for %s", what));
		end
		while (flagValue(which) !== level);
	endtask

	task automatic waitStable;
		int cycles;
		int still;
		logic [23:0] last;
		cycles = 0;
		still = 0;
		@(negedge txCLK);
		last = {trigOut, ledOut, transducerOut};
		while (still < 4)
		begin
			@(negedge txCLK);
			cycles++;
			if (cycles > 100)
				reportFailure("outputs kept changing for 100 cycles");
			if ({trigOut, ledOut, transducerOut} == last)
				still++;
			else
				still = 0;
			last = {trigOut, ledOut, transducerOut};
		end
	endtask

	task automatic setCmd(input txCmd_e cmd);
		@(posedge txCLK);
		txCmd <= cmd;
	endtask

	task automatic writeProgram;
		progWrite_t entry;
		setCmd(loadProgram);
		@(posedge txCLK);
		for (int i = 0; i < prog.size(); i++)
		begin
			entry.valid = 1'b1;
			entry.addr = i[progAddrWidth-1:0];
			entry.word = prog[i];
			@(posedge txCLK);
			progWrite <= entry;
		end
		@(posedge txCLK);
		progWrite <= '0;
		setCmd(idleCommand());
	endtask

	// counts until done and a pulse-free stretch longer than any delay
	task automatic countPulses;
		int cycles;
		int quiet;
		cycles = 0;
		quiet = 0;
		foreach (pulseCount[ch])
			pulseCount[ch] = 0;
		while (!(status.done && quiet >= 40))
		begin
			@(negedge txCLK);
			cycles++;
			if (cycles > 400)
				reportFailure("pulses did not end within 400 cycles");
			for (int ch = 0; ch < numChannels; ch++)
				pulseCount[ch] += transducerOut[ch];
			quiet = (transducerOut == '0) ? quiet + 1 : 0;
		end
	endtask

	always @(negedge txCLK)
	begin : compareOutputs
		logic [15:0] want;
		if (monitorOn && ({trigOut, ledOut} != lastSeen))
		begin
			if (expected.size() == 0)
				reportFailure("trigOut or ledOut changed past the end of the reference sequence");
			else
			begin
				want = expected.pop_front();
				checkByte("trigOut", trigOut, want[15:8]);
				checkByte("ledOut", ledOut, want[7:0]);
				lastSeen = {trigOut, ledOut};
			end
		end
	end

	task automatic checkManualModes;
		manualRegs_t regs;
		logic [15:0] value;
		waitStable;
		checkByte("trigOut", trigOut, 8'h00);
		checkByte("ledOut", ledOut, 8'h00);
		checkByte("transducerOut", transducerOut, 8'h00);
		checkStatus("status", status, '0);
		drawBits(8, value);
		restLevel = value[7:0];
		regs.trigRest = restLevel;
		drawBits(8, value);
		regs.trig = value[7:0];
		drawBits(8, value);
		regs.led = value[7:0];
		@(posedge txCLK);
		manualRegs <= regs;
		setCmd(setTrigRest);
		setCmd(idleCommand());
		waitStable;
		checkByte("trigOut", trigOut, restLevel);
		checkByte("ledOut", ledOut, 8'h00);
		setCmd(setTrig);
		waitStable;
		checkByte("trigOut", trigOut, regs.trig);
		setCmd(setLed);
		waitStable;
		checkByte("ledOut", ledOut, regs.led);
		checkByte("trigOut", trigOut, regs.trig);
		setCmd(testTrig);
		waitStable;
		checkByte("trigOut", trigOut, regs.trig ^ restLevel);
		checkByte("ledOut", ledOut, regs.led);
		setCmd(idleCommand());
	endtask

	task automatic runOutputProgram;
		txOpcode_e op;
		logic [15:0] value;
		logic [15:0] arg;
		logic [15:0] prevOut;
		logic [15:0] nextOut;
		prog.delete();
		expected.delete();
		prevOut = {restLevel, 8'h00};
		for (int i = 0; i < 12; i++)
		begin
			drawBits(1, value);
			op = value[0] ? setLedsOp : setTrigOp;
			drawBits(16, arg);
			drawBits(2, value);
			prog.push_back(makeInstr(op, arg, value));
			nextOut = refOutputs(prog[i], restLevel, prevOut);
			if (nextOut != prevOut)
				expected.push_back(nextOut);
			prevOut = nextOut;
		end
		prog.push_back(makeInstr(programEndOp, 16'h0, 16'h0));
		writeProgram;
		lastSeen = {restLevel, 8'h00};
		monitorOn = 1'b1;
		setCmd(runProgram);
		waitFlag(0, 1'b1, "status.done after the output program");
		waitStable;
		monitorOn = 1'b0;
		if (expected.size() != 0)
			reportFailure($sformatf("%0d expected output changes never appeared", expected.size()));
		checkStatus("status", status, '{1'b0, 1'b1, 1'b0});
		setCmd(idleCommand());
	endtask

	task automatic runAdcProgram;
		prog.delete();
		prog.push_back(makeInstr(triggerRecvOp, 16'h0, 16'h2));
		prog.push_back(makeInstr(programEndOp, 16'h0, 16'h0));
		writeProgram;
		setCmd(runProgram);
		waitFlag(2, 1'b1, "adcTrigger to rise");
		// the program runs on to its end while the trigger waits for adcAck
		waitFlag(0, 1'b1, "status.done after the ADC program");
		if (adcTrigger !== 1'b1)
			reportFailure("adcTrigger dropped before adcAck was given");
		@(posedge txCLK);
		adcAck <= 1'b1;
		waitFlag(2, 1'b0, "adcTrigger to fall after adcAck");
		@(posedge txCLK);
		adcAck <= 1'b0;
		setCmd(idleCommand());
	endtask

	task automatic runFireProgram;
		logic [15:0] value;
		logic [7:0] mask;
		for (int ch = 0; ch < numChannels; ch++)
		begin
			drawBits(4, value);
			timings[ch].delay = value;
			drawBits(4, value);
			timings[ch].width = (value == '0) ? 16'd1 : value;
		end
		drawBits(8, value);
		mask = value[7:0];
		@(posedge txCLK);
		chanTiming <= timings;
		chanMask <= mask;
		prog.delete();
		prog.push_back(makeInstr(firePulseOp, 16'h0, 16'h0));
		prog.push_back(makeInstr(programEndOp, 16'h0, 16'h0));
		writeProgram;
		setCmd(runProgram);
		countPulses;
		for (int ch = 0; ch < numChannels; ch++)
			checkByte($sformatf("transducerOut[%0d] high cycles", ch), 8'(pulseCount[ch]),
				mask[ch] ? timings[ch].width[7:0] : 8'h00);
		setCmd(idleCommand());
	endtask

	task automatic runFaultProgram;
		logic [7:0] longChans;
		logic [7:0] expErr;
		int holdCycles;
		longChans = 8'hA5;
		holdCycles = 4;
		expErr = '0;
		for (int ch = 0; ch < numChannels; ch++)
		begin
			// long channels are already pulsing when the second fire arrives
			timings[ch].delay = longChans[ch] ? 16'd2 : 16'd0;
			timings[ch].width = longChans[ch] ? 16'd16 : 16'd2;
			// second fire executes holdCycles + 3 cycles after the first
			if (timings[ch].delay + timings[ch].width > holdCycles + 3)
				expErr[ch] = 1'b1;
		end
		@(posedge txCLK);
		chanTiming <= timings;
		chanMask <= 8'hFF;
		prog.delete();
		prog.push_back(makeInstr(firePulseOp, 16'h0, holdCycles[15:0]));
		prog.push_back(makeInstr(firePulseOp, 16'h0, 16'h0));
		prog.push_back(makeInstr(programEndOp, 16'h0, 16'h0));
		writeProgram;
		setCmd(runProgram);
		waitFlag(1, 1'b1, "status.fault after the second fire");
		// one cycle for the output register, then low past the end of the long pulses
		repeat (16)
		begin
			@(negedge txCLK);
			checkByte("transducerOut", transducerOut, 8'h00);
		end
		checkByte("transducerErr", transducerErr, expErr);
		checkStatus("status", status, '{1'b0, 1'b0, 1'b1});
		setCmd(softReset);
		waitFlag(1, 1'b0, "status.fault to clear after softReset");
		waitStable;
		checkByte("transducerErr", transducerErr, 8'h00);
		checkStatus("status", status, '0);
		setCmd(idleCommand());
	endtask

	initial
	begin
		txCmd <= idleCommand();
		manualRegs <= '0;
		progWrite <= '0;
		chanTiming <= '0;
		chanMask <= '0;
		adcAck <= 1'b0;
		rstN <= 1'b0;
		repeat (3) @(posedge txCLK);
		rstN <= 1'b1;
		checkManualModes;
		runOutputProgram;
		runAdcProgram;
		runFireProgram;
		runFaultProgram;
		if (sonicTxTop_inst.propsInst.failCount == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

/* sonicTxTop.f */
verilog/txCtrlPkg.sv
verilog/txProgPkg.sv
verilog/txModeControl.sv
verilog/programMemory.sv
verilog/instructionSequencer.sv
verilog/pulseChannel.sv
verilog/txOutputStage.sv
verilog/sonicTxTop.sv
test/sonicTx_properties.sv
test/sonicTxTb.sv

/* Bender.yml */
package:
  name: sonic_tx

sources:
  # packages first, the RTL depends on them
  - verilog/txCtrlPkg.sv
  - verilog/txProgPkg.sv
  - verilog/txModeControl.sv
  - verilog/programMemory.sv
  - verilog/instructionSequencer.sv
  - verilog/pulseChannel.sv
  - verilog/txOutputStage.sv
  - verilog/sonicTxTop.sv
  - target: test
    files:
      - test/sonicTx_properties.sv
      - test/sonicTxTb.sv
